/* include/spi_consts.svh */
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// FIFO geometry
`define SPI_FIFO_AW      4

// Register offsets on the APB bus
`define SPI_REG_TXDATA   4'h0
`define SPI_REG_RXDATA   4'h4
`define SPI_REG_STATUS   4'h8
`define SPI_REG_CTRL     4'hC

// TXDATA field, bit 8 keeps chip select low after the byte
`define SPI_TX_HOLD_CS   8

// STATUS bit positions
`define SPI_ST_TX_EMPTY  0
`define SPI_ST_TX_FULL   1
`define SPI_ST_RX_AVAIL  2
`define SPI_ST_RX_FULL   3
`define SPI_ST_BUSY      4
`define SPI_ST_OVERFLOW  5

// CTRL fields
`define SPI_CTRL_CLR_OVF 16
`define SPI_DIV_RESET    8'd1

`endif

/* verilog/spi_pkg.sv */
package spi_pkg;

  // One SPI data byte
  typedef logic [7:0] spi_byte_t;

  // Transmit FIFO entry
  typedef struct packed {
    logic      hold_cs;
    spi_byte_t data;
  } tx_entry_t;

  ////////////////////////////////////////
  // APB request and response halves
  ////////////////////////////////////////
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Pins driven by the master
  typedef struct packed {
    logic sck;
    logic mosi;
    logic cs_n;
  } spi_pins_t;

  // Flags of one FIFO
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_status_t;

endpackage

/* verilog/spi_fifo.sv */
`include "spi_consts.svh"

module spi_fifo #(
  parameter type T  = spi_pkg::spi_byte_t,
  parameter int  AW = `SPI_FIFO_AW
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_push,
  input  logic                  i_pop,
  input  T                      i_data,
  output T                      o_q,
  output spi_pkg::fifo_status_t o_status
);

  localparam int DEPTH = 1 << AW;

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  // Requests beyond the flags are dropped here
  assign do_push = i_push && !o_status.full;
  assign do_pop  = i_pop && !o_status.empty;

  assign o_status.empty = (count == '0);
  assign o_status.full  = (count == DEPTH[AW:0]);
  assign o_q            = mem[rd_ptr];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= i_data;
  end

  a_count_bound : assert property (@(posedge clk) disable iff (rst) count <= DEPTH);
  // Pointer distance tracks the fill level
  a_ptr_count : assert property (@(posedge clk) disable iff (rst)
    (wr_ptr - rd_ptr) == count[AW-1:0]);

endmodule

/* verilog/spi_apb_decode.sv */
`include "spi_consts.svh"

module spi_apb_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  spi_pkg::apb_req_t     i_apb,
  output spi_pkg::apb_rsp_t     o_apb,
  output logic                  o_tx_push,
  output spi_pkg::tx_entry_t    o_tx_entry,
  input  spi_pkg::fifo_status_t i_tx_status,
  output logic                  o_rx_pop,
  input  spi_pkg::spi_byte_t    i_rx_q,
  input  spi_pkg::fifo_status_t i_rx_status,
  input  logic                  i_busy,
  input  logic                  i_overflow,
  output logic [7:0]            o_div,
  output logic                  o_clr_ovf
);

  import spi_pkg::*;

  logic        wr_acc;
  logic        rd_acc;
  logic        sel_tx;
  logic        sel_rx;
  logic        sel_st;
  logic        sel_ctrl;
  logic        unmapped;
  logic [31:0] status_word;
  spi_byte_t   div_q;

  ////////////////////////////////////////
  // Access cycle decode
  ////////////////////////////////////////
  assign wr_acc   = i_apb.psel && i_apb.penable && i_apb.pwrite;
  assign rd_acc   = i_apb.psel && i_apb.penable && !i_apb.pwrite;
  assign sel_tx   = (i_apb.paddr == `SPI_REG_TXDATA);
  assign sel_rx   = (i_apb.paddr == `SPI_REG_RXDATA);
  assign sel_st   = (i_apb.paddr == `SPI_REG_STATUS);
  assign sel_ctrl = (i_apb.paddr == `SPI_REG_CTRL);
  assign unmapped = !(sel_tx || sel_rx || sel_st || sel_ctrl);

  // FIFO strobes, guarded by the flags
  assign o_tx_push          = wr_acc && sel_tx && !i_tx_status.full;
  assign o_tx_entry.data    = i_apb.pwdata[7:0];
  assign o_tx_entry.hold_cs = i_apb.pwdata[`SPI_TX_HOLD_CS];
  assign o_rx_pop           = rd_acc && sel_rx && !i_rx_status.empty;
  assign o_clr_ovf          = wr_acc && sel_ctrl && i_apb.pwdata[`SPI_CTRL_CLR_OVF];

  // Divider in CTRL[7:0]
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_q <= `SPI_DIV_RESET;
    end else if (wr_acc && sel_ctrl) begin
      div_q <= i_apb.pwdata[7:0];
    end
  end
  assign o_div = div_q;

  always_comb begin
    status_word                    = '0;
    status_word[`SPI_ST_TX_EMPTY]  = i_tx_status.empty;
    status_word[`SPI_ST_TX_FULL]   = i_tx_status.full;
    status_word[`SPI_ST_RX_AVAIL]  = !i_rx_status.empty;
    status_word[`SPI_ST_RX_FULL]   = i_rx_status.full;
    status_word[`SPI_ST_BUSY]      = i_busy;
    status_word[`SPI_ST_OVERFLOW]  = i_overflow;
  end

  // Read mux, zero latency
  always_comb begin
    o_apb.prdata = '0;
    if (sel_rx && !i_rx_status.empty) o_apb.prdata = {24'b0, i_rx_q};
    if (sel_st) o_apb.prdata = status_word;
    if (sel_ctrl) o_apb.prdata = {24'b0, div_q};
  end

  assign o_apb.pready  = 1'b1;
  assign o_apb.pslverr = (i_apb.psel && i_apb.penable && unmapped) ||
                         (wr_acc && sel_tx && i_tx_status.full) ||
                         (rd_acc && sel_rx && i_rx_status.empty);

  // A setup phase is always followed by its own access phase
  a_apb_access : assert property (@(posedge clk) disable iff (rst)
    (i_apb.psel && !i_apb.penable) |=>
      (i_apb.psel && i_apb.penable && $stable(i_apb.paddr) && $stable(i_apb.pwrite)));

endmodule

/* verilog/spi_shift_engine.sv */
module spi_shift_engine (
  input  logic                  clk,
  input  logic                  rst,
  input  spi_pkg::tx_entry_t    i_tx_q,
  input  spi_pkg::fifo_status_t i_tx_status,
  output logic                  o_tx_pop,
  input  logic [7:0]            i_div,
  input  logic                  i_miso,
  output spi_pkg::spi_pins_t    o_spi,
  output logic                  o_busy,
  output logic                  o_rx_valid,
  output spi_pkg::spi_byte_t    o_rx_byte
);

  import spi_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_GAP
  } state_t;

  state_t    state;
  logic [7:0] div_cnt;
  logic [2:0] bit_cnt;
  logic      phase;
  logic      cs_n_q;
  logic      mosi_q;
  logic      hold_q;
  spi_byte_t tx_sh;
  spi_byte_t rx_sh;
  logic      half_end;
  logic      rise;
  logic      fall;
  logic      byte_end;
  logic      load;

  ////////////////////////////////////////
  // Bit timing strobes
  ////////////////////////////////////////
  assign half_end = (div_cnt >= i_div);
  assign rise     = (state == ST_SHIFT) && !phase && half_end;
  assign fall     = (state == ST_SHIFT) && phase && half_end;
  assign byte_end = fall && (bit_cnt == 3'd7);
  // Start from idle, or chain straight on when chip select is held
  assign load = ((state == ST_IDLE) || (byte_end && hold_q)) && !i_tx_status.empty;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= ST_IDLE;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      phase    <= 1'b0;
      cs_n_q   <= 1'b1;
      mosi_q   <= 1'b0;
      hold_q   <= 1'b0;
      o_tx_pop <= 1'b0;
    end else begin
      o_tx_pop <= 1'b0;
      if (load) begin
        state    <= ST_SHIFT;
        div_cnt  <= '0;
        bit_cnt  <= '0;
        phase    <= 1'b0;
        cs_n_q   <= 1'b0;
        mosi_q   <= i_tx_q.data[7];
        hold_q   <= i_tx_q.hold_cs;
        o_tx_pop <= 1'b1;
      end else if (state == ST_SHIFT) begin
        div_cnt <= half_end ? '0 : div_cnt + 1'b1;
        if (half_end) phase <= ~phase;
        if (byte_end) begin
          // Held frame with nothing queued parks with cs_n low
          state  <= hold_q ? ST_IDLE : ST_GAP;
          cs_n_q <= hold_q ? 1'b0 : 1'b1;
        end else if (fall) begin
          bit_cnt <= bit_cnt + 1'b1;
          mosi_q  <= tx_sh[6];
        end
      end else if (state == ST_GAP) begin
        div_cnt <= half_end ? '0 : div_cnt + 1'b1;
        if (half_end) state <= ST_IDLE;
      end
    end
  end

  // Shift registers, MOSI out MSB first and MISO in on the rising edge
  always_ff @(posedge clk) begin
    if (load) tx_sh <= i_tx_q.data;
    else if (fall) tx_sh <= {tx_sh[6:0], 1'b0};
    if (rise) rx_sh <= {rx_sh[6:0], i_miso};
  end

  assign o_spi.sck  = phase;
  assign o_spi.mosi = mosi_q;
  assign o_spi.cs_n = cs_n_q;
  assign o_busy     = (state != ST_IDLE);
  // Last cycle of bit 7, all eight samples already in
  assign o_rx_valid = byte_end;
  assign o_rx_byte  = rx_sh;

  a_cs_while_shift : assert property (@(posedge clk) disable iff (rst)
    (state == ST_SHIFT) |-> !o_spi.cs_n);
  a_sck_idle_low : assert property (@(posedge clk) disable iff (rst)
    o_spi.cs_n |-> !o_spi.sck);

endmodule

/* verilog/spi_rx_result.sv */
module spi_rx_result (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_rx_valid,
  input  spi_pkg::spi_byte_t    i_rx_byte,
  input  spi_pkg::fifo_status_t i_rx_status,
  input  logic                  i_clr_ovf,
  output logic                  o_push,
  output spi_pkg::spi_byte_t    o_data,
  output logic                  o_overflow
);

  import spi_pkg::*;

  logic      valid_q;
  spi_byte_t data_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q    <= 1'b0;
      o_overflow <= 1'b0;
    end else begin
      valid_q <= i_rx_valid;
      // A drop in the same cycle as a clear still counts
      if (valid_q && i_rx_status.full) o_overflow <= 1'b1;
      else if (i_clr_ovf) o_overflow <= 1'b0;
    end
  end

  // Captured byte
  always_ff @(posedge clk) begin
    if (i_rx_valid) data_q <= i_rx_byte;
  end

  // Full FIFO never stalls the engine
  assign o_push = valid_q && !i_rx_status.full;
  assign o_data = data_q;

endmodule

/* verilog/spi_apb_top.sv */
module spi_apb_top (
  input  logic               clk,
  input  logic               rst,
  input  spi_pkg::apb_req_t  i_apb,
  output spi_pkg::apb_rsp_t  o_apb,
  output spi_pkg::spi_pins_t o_spi,
  input  logic               i_miso
);

  import spi_pkg::*;

  logic         tx_push;
  logic         tx_pop;
  tx_entry_t    tx_entry;
  tx_entry_t    tx_q;
  fifo_status_t tx_status;
  logic         rx_pop;
  logic         rx_push;
  spi_byte_t    rx_data;
  spi_byte_t    rx_q;
  fifo_status_t rx_status;
  logic         rx_valid;
  spi_byte_t    rx_byte;
  logic         busy;
  logic         overflow;
  logic         clr_ovf;
  logic [7:0]   div;

  ////////////////////////////////////////
  // FIFOs
  ////////////////////////////////////////
  spi_fifo #(.T(tx_entry_t)) u_tx_fifo (
    .clk(clk), .rst(rst), .i_push(tx_push), .i_pop(tx_pop),
    .i_data(tx_entry), .o_q(tx_q), .o_status(tx_status)
  );

  spi_fifo #(.T(spi_byte_t)) u_rx_fifo (
    .clk(clk), .rst(rst), .i_push(rx_push), .i_pop(rx_pop),
    .i_data(rx_data), .o_q(rx_q), .o_status(rx_status)
  );

  // Register block, shifter and receive capture
  spi_apb_decode u_decode (
    .clk(clk), .rst(rst), .i_apb(i_apb), .o_apb(o_apb),
    .o_tx_push(tx_push), .o_tx_entry(tx_entry), .i_tx_status(tx_status),
    .o_rx_pop(rx_pop), .i_rx_q(rx_q), .i_rx_status(rx_status),
    .i_busy(busy), .i_overflow(overflow), .o_div(div), .o_clr_ovf(clr_ovf)
  );

  spi_shift_engine u_engine (
    .clk(clk), .rst(rst), .i_tx_q(tx_q), .i_tx_status(tx_status),
    .o_tx_pop(tx_pop), .i_div(div), .i_miso(i_miso), .o_spi(o_spi),
    .o_busy(busy), .o_rx_valid(rx_valid), .o_rx_byte(rx_byte)
  );

  spi_rx_result u_result (
    .clk(clk), .rst(rst), .i_rx_valid(rx_valid), .i_rx_byte(rx_byte),
    .i_rx_status(rx_status), .i_clr_ovf(clr_ovf), .o_push(rx_push),
    .o_data(rx_data), .o_overflow(overflow)
  );

endmodule

/* bench/spi_tb_clock.sv */
module spi_tb_clock #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Reset drops just after the last held edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1 o_rst = 1'b0;
  end

endmodule

/* bench/spi_tb.sv */
`include "spi_consts.svh"

module spi_tb;

  import spi_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int DRIVE_DELAY = 1;
  // Worst-case byte time is 16 * (div + 1) clk cycles
  localparam int BYTE_D1     = 16 * 2;
  localparam int BYTE_D3     = 16 * 4;
  localparam int BYTE_D255   = 16 * 256;
  localparam int WATCHDOG_TIME = CLK_PERIOD * 2 *
    (BYTE_D1 + 16 * BYTE_D1 + 2 * BYTE_D3 + 17 * BYTE_D1 + BYTE_D255);

  logic        clk;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  spi_pins_t   spi_pins;
  logic [15:0] lfsr_q;
  int          cyc_cnt;
  int          cs_falls;
  int          cs_rises;
  int          rise_times[$];
  logic        sck_d;
  logic        cs_d;

  spi_tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) u_clock (.o_clk(clk), .o_rst(rst));

  // MOSI looped back onto MISO
  spi_apb_top u_spi_apb_top (
    .clk(clk), .rst(rst), .i_apb(apb_req), .o_apb(apb_rsp),
    .o_spi(spi_pins), .i_miso(spi_pins.mosi)
  );

  ////////////////////////////////////////
  // Pin monitor, sampled mid-cycle
  ////////////////////////////////////////
  always @(negedge clk) begin
    cyc_cnt++;
    if (!rst) begin
      if (spi_pins.sck && !sck_d) rise_times.push_back(cyc_cnt);
      if (!spi_pins.cs_n && cs_d) cs_falls++;
      if (spi_pins.cs_n && !cs_d) cs_rises++;
    end
    sck_d = spi_pins.sck;
    cs_d  = spi_pins.cs_n;
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_next_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic spi_byte_t random_byte();
    spi_byte_t b;
    b = '0;
    for (int i = 0; i < 8; i++) b = {b[6:0], lfsr_next_bit()};
    return b;
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("mismatch in %s, %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_cond(input string test, input logic cond, input string what);
    assert (cond) else begin
      $display("%s: %s", test, what);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
    end
  endtask

  ////////////////////////////////////////
  // APB access, called one unit after a rising edge
  ////////////////////////////////////////
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk);
    #(DRIVE_DELAY);
    apb_req.penable = 1'b1;
    @(negedge clk);
    err = apb_rsp.pslverr;
    check_cond("apb_write", apb_rsp.pready, "pready is low in the access cycle");
    @(posedge clk);
    #(DRIVE_DELAY);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(posedge clk);
    #(DRIVE_DELAY);
    apb_req.penable = 1'b1;
    @(negedge clk);
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    check_cond("apb_read", apb_rsp.pready, "pready is low in the access cycle");
    @(posedge clk);
    #(DRIVE_DELAY);
    apb_req = '0;
  endtask

  task automatic reg_write(input string test, input logic [3:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_value(test, "pslverr on write", 32'h0, {31'h0, err});
  endtask

  task automatic reg_read(input string test, input logic [3:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check_value(test, "pslverr on read", 32'h0, {31'h0, err});
  endtask

  task automatic tx_write(input string test, input spi_byte_t data, input logic hold);
    logic [31:0] w;
    w = {24'h0, data};
    w[`SPI_TX_HOLD_CS] = hold;
    reg_write(test, `SPI_REG_TXDATA, w);
  endtask

  // Poll STATUS until the engine is idle with nothing queued
  task automatic wait_idle(input string test);
    logic [31:0] st;
    st = '0;
    while (st[`SPI_ST_BUSY] || !st[`SPI_ST_TX_EMPTY]) reg_read(test, `SPI_REG_STATUS, st);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic test_reset();
    logic [31:0] d;
    logic [31:0] exp_st;
    exp_st = '0;
    exp_st[`SPI_ST_TX_EMPTY] = 1'b1;
    reg_read("reset", `SPI_REG_STATUS, d);
    check_value("reset", "STATUS", exp_st, d);
    reg_read("reset", `SPI_REG_CTRL, d);
    check_value("reset", "CTRL divider", {24'h0, `SPI_DIV_RESET}, d);
    check_cond("reset", spi_pins.cs_n, "chip select is not high after reset");
  endtask

  task automatic test_single_byte();
    logic [31:0] d;
    int          f0;
    int          r0;
    f0 = cs_falls;
    r0 = cs_rises;
    tx_write("single_byte", 8'hA5, 1'b0);
    wait_idle("single_byte");
    reg_read("single_byte", `SPI_REG_RXDATA, d);
    check_value("single_byte", "RXDATA", 32'hA5, d);
    check_value("single_byte", "cs_n falling edges", 32'd1, cs_falls - f0);
    check_value("single_byte", "cs_n rising edges", 32'd1, cs_rises - r0);
    check_cond("single_byte", spi_pins.cs_n, "chip select still low after the transfer");
  endtask

  task automatic test_burst();
    spi_byte_t   exp_q[$];
    spi_byte_t   b;
    logic [31:0] d;
    int          f0;
    int          r0;
    f0 = cs_falls;
    r0 = cs_rises;
    for (int i = 0; i < 16; i++) begin
      b = random_byte();
      exp_q.push_back(b);
      tx_write("burst", b, (i != 15));
    end
    wait_idle("burst");
    // One frame means exactly one fall and one rise
    check_value("burst", "cs_n falling edges", 32'd1, cs_falls - f0);
    check_value("burst", "cs_n rising edges", 32'd1, cs_rises - r0);
    for (int i = 0; i < 16; i++) begin
      reg_read("burst", `SPI_REG_RXDATA, d);
      check_value("burst", "RXDATA in order", {24'h0, exp_q[i]}, d);
    end
  endtask

  task automatic test_sck_timing();
    spi_byte_t   b;
    logic [31:0] d;
    int          div;
    div = 3;
    reg_write("sck_timing", `SPI_REG_CTRL, div);
    repeat (2) begin
      rise_times.delete();
      b = random_byte();
      tx_write("sck_timing", b, 1'b0);
      wait_idle("sck_timing");
      check_value("sck_timing", "sck rises per byte", 32'd8, rise_times.size());
      for (int i = 1; i < rise_times.size(); i++) begin
        check_value("sck_timing", "clk cycles between sck rises", 2 * (div + 1),
                    rise_times[i] - rise_times[i-1]);
      end
      reg_read("sck_timing", `SPI_REG_RXDATA, d);
      check_value("sck_timing", "RXDATA", {24'h0, b}, d);
    end
    reg_write("sck_timing", `SPI_REG_CTRL, {24'h0, `SPI_DIV_RESET});
  endtask

  task automatic test_overflow();
    spi_byte_t   exp_q[$];
    spi_byte_t   b;
    logic [31:0] d;
    logic [31:0] w;
    logic        err;
    for (int i = 0; i < 17; i++) begin
      b = random_byte();
      exp_q.push_back(b);
      tx_write("overflow", b, 1'b0);
    end
    wait_idle("overflow");
    reg_read("overflow", `SPI_REG_STATUS, d);
    check_value("overflow", "STATUS overflow", 32'h1, {31'h0, d[`SPI_ST_OVERFLOW]});
    check_value("overflow", "STATUS rx_full", 32'h1, {31'h0, d[`SPI_ST_RX_FULL]});
    w = {24'h0, `SPI_DIV_RESET};
    w[`SPI_CTRL_CLR_OVF] = 1'b1;
    reg_write("overflow", `SPI_REG_CTRL, w);
    reg_read("overflow", `SPI_REG_STATUS, d);
    check_value("overflow", "STATUS overflow after clear", 32'h0, {31'h0, d[`SPI_ST_OVERFLOW]});
    // The 17th byte was dropped
    for (int i = 0; i < 16; i++) begin
      reg_read("overflow", `SPI_REG_RXDATA, d);
      check_value("overflow", "RXDATA in order", {24'h0, exp_q[i]}, d);
    end
    apb_read(`SPI_REG_RXDATA, d, err);
    check_value("overflow", "pslverr on empty RXDATA", 32'h1, {31'h0, err});
    check_value("overflow", "RXDATA when empty", 32'h0, d);
  endtask

  task automatic test_tx_full();
    logic [31:0] d;
    logic        err;
    reg_write("tx_full", `SPI_REG_CTRL, 32'd255);
    tx_write("tx_full", random_byte(), 1'b0);
    reg_read("tx_full", `SPI_REG_STATUS, d);
    check_value("tx_full", "STATUS busy", 32'h1, {31'h0, d[`SPI_ST_BUSY]});
    repeat (16) tx_write("tx_full", random_byte(), 1'b0);
    reg_read("tx_full", `SPI_REG_STATUS, d);
    check_value("tx_full", "STATUS tx_full", 32'h1, {31'h0, d[`SPI_ST_TX_FULL]});
    apb_write(`SPI_REG_TXDATA, 32'h5A, err);
    check_value("tx_full", "pslverr on full TXDATA", 32'h1, {31'h0, err});
    // Unmapped offsets inside the 4-bit window
    apb_read(4'h2, d, err);
    check_value("tx_full", "pslverr on unmapped read", 32'h1, {31'h0, err});
    apb_write(4'hE, 32'h0, err);
    check_value("tx_full", "pslverr on unmapped write", 32'h1, {31'h0, err});
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired after %0d time units, a test is stuck", WATCHDOG_TIME);
  end

  initial begin
    apb_req  = '0;
    lfsr_q   = 16'd41;
    cyc_cnt  = 0;
    cs_falls = 0;
    cs_rises = 0;
    sck_d    = 1'b0;
    cs_d     = 1'b1;
    @(negedge rst);
    @(posedge clk);
    #(DRIVE_DELAY);
    test_reset();
    test_single_byte();
    test_burst();
    test_sck_timing();
    test_overflow();
    test_tx_full();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* spi_master.f */
+incdir+include
verilog/spi_pkg.sv
verilog/spi_fifo.sv
verilog/spi_apb_decode.sv
verilog/spi_shift_engine.sv
verilog/spi_rx_result.sv
verilog/spi_apb_top.sv
bench/spi_tb_clock.sv
bench/spi_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spi_tb -f spi_master.f -o spi_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/spi_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -F -q '*** TEST FAILED ***' sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0
